// File: hw/opc_pkg.sv
package opc_pkg;

   // --------------------
   // datapath types

   // one machine word; data, addresses and instructions alike.
   typedef logic [15:0] word_t;

   // names one tile of the cluster.
   typedef logic [1:0] core_idx_t;

   // --------------------
   // core sequencing

   typedef enum logic [2:0] {
      fetch0,
      fetch1,
      ea_ed,
      rdmem,
      exec,
      wrmem
   } cpu_state_t;

   // stores here leave the tile as output words.
   localparam word_t OUT_ADDR = 16'hFFFF;

endpackage

// File: hw/opc_cpu.sv
`timescale 1ns/1ns

module opc_cpu (
   input  logic           clk,
   input  logic           reset_b,
   input  logic           run,
   input  opc_pkg::word_t din,
   output opc_pkg::word_t dout,
   output opc_pkg::word_t address,
   output logic           rnw
);
   import opc_pkg::*;

   localparam logic [3:0] OP_MOV  = 4'h0;
   localparam logic [3:0] OP_AND  = 4'h1;
   localparam logic [3:0] OP_OR   = 4'h2;
   localparam logic [3:0] OP_XOR  = 4'h3;
   localparam logic [3:0] OP_ADD  = 4'h4;
   localparam logic [3:0] OP_ADC  = 4'h5;
   localparam logic [3:0] OP_STO  = 4'h6;
   localparam logic [3:0] OP_LD   = 4'h7;
   localparam logic [3:0] OP_ROR  = 4'h8;
   localparam logic [3:0] OP_NOT  = 4'h9;
   localparam logic [3:0] OP_SUB  = 4'hA;
   localparam logic [3:0] OP_SBC  = 4'hB;
   localparam logic [3:0] OP_CMP  = 4'hC;
   localparam logic [3:0] OP_CMPC = 4'hD;
   localparam logic [3:0] OP_BSWP = 4'hE;
   localparam logic [3:0] OP_PSR  = 4'hF;

   // bit positions in the decoded instruction register.
   localparam int PRED_C   = 15;
   localparam int PRED_Z   = 14;
   localparam int PINVERT  = 13;
   localparam int IRLEN    = 12;
   localparam int IRLD     = 16;
   localparam int IRSTO    = 17;
   localparam int IRGETPSR = 18;
   localparam int IRPUTPSR = 19;
   localparam int IRCMP    = 20;

   word_t       pc_q;
   word_t       or_q;
   word_t       result;
   word_t       grf_dout;
   word_t       grf_q [16];
   logic [20:0] ir_q;
   logic [3:0]  grf_radr_q;
   cpu_state_t  state_q;
   logic        c_q;
   logic        z_q;
   logic        carry;
   logic        zero;
   logic        predicate;
   logic        predicate_din;
   logic        skip_eaed;
   logic        dest_pc;

   // din form is needed in fetch0, before ir_q holds the word.
   assign predicate     = ir_q[PINVERT] ^ ((ir_q[PRED_C] | c_q) & (ir_q[PRED_Z] | z_q));
   assign predicate_din = din[PINVERT] ^ ((din[PRED_C] | c_q) & (din[PRED_Z] | z_q));

   // r0 reads zero, r15 is the pc.
   assign grf_dout = (grf_radr_q == 4'hF) ? pc_q :
                     (grf_q[grf_radr_q] & {16{grf_radr_q != 4'h0}});

   assign skip_eaed = !((grf_radr_q != 4'h0) || ir_q[IRLD] || ir_q[IRSTO]);
   assign dest_pc   = (ir_q[3:0] == 4'hF);

   assign rnw     = !(run && state_q == wrmem);
   assign dout    = grf_dout;
   assign address = (state_q == wrmem || state_q == rdmem) ? or_q : pc_q;

   // --------------------
   // alu
   always_comb
   begin
      carry  = c_q;
      result = or_q;
      case (ir_q[11:8])
         OP_LD, OP_MOV, OP_PSR, OP_STO:
            result = ir_q[IRGETPSR] ? {14'b0, c_q, z_q} : or_q;
         OP_AND, OP_OR:
            result = ir_q[8] ? (grf_dout & or_q) : (grf_dout | or_q);
         OP_ADD, OP_ADC:
            {carry, result} = {1'b0, grf_dout} + {1'b0, or_q} + {16'b0, ir_q[8] & c_q};
         OP_SUB, OP_SBC, OP_CMP, OP_CMPC:
            {carry, result} = {1'b0, grf_dout} + {1'b0, ~or_q} +
                              {16'b0, ir_q[8] ? c_q : 1'b1};
         OP_XOR, OP_BSWP:
            result = ir_q[11] ? {or_q[7:0], or_q[15:8]} : (grf_dout ^ or_q);
         OP_NOT, OP_ROR:
            {result, carry} = ir_q[8] ? {~or_q, c_q} : {c_q, or_q};
      endcase

      // flags stay put when the pc is the destination.
      if (ir_q[IRPUTPSR])
         {carry, zero} = or_q[1:0];
      else if (!dest_pc)
         zero = ~|result;
      else
      begin
         carry = c_q;
         zero  = z_q;
      end
   end

   // --------------------
   // sequencing
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         state_q <= fetch0;
      else if (!run)
         state_q <= fetch0;
      else
      begin
         case (state_q)
            fetch0:
               state_q <= din[IRLEN] ? fetch1 : (predicate_din ? ea_ed : fetch0);
            fetch1:
               state_q <= !predicate ? fetch0 : (skip_eaed ? exec : ea_ed);
            ea_ed:
               state_q <= !predicate ? fetch0 :
                          ir_q[IRLD] ? rdmem :
                          ir_q[IRSTO] ? wrmem : exec;
            rdmem:
               state_q <= exec;
            exec:
               state_q <= dest_pc ? fetch0 : (din[IRLEN] ? fetch1 : ea_ed);
            default:
               state_q <= fetch0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      case (state_q)
         fetch0, exec:
         begin
            grf_radr_q <= din[7:4];
            or_q       <= '0;
         end
         fetch1:
         begin
            grf_radr_q <= skip_eaed ? ir_q[3:0] : ir_q[7:4];
            or_q       <= din;
         end
         rdmem:
         begin
            grf_radr_q <= ir_q[3:0];
            or_q       <= din;
         end
         ea_ed:
         begin
            grf_radr_q <= ir_q[3:0];
            or_q       <= grf_dout + or_q;
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         pc_q <= '0;
      else if (!run)
         pc_q <= '0;
      else if (state_q == fetch0 || state_q == fetch1)
         pc_q <= pc_q + 16'd1;
      else if (state_q == exec)
         pc_q <= dest_pc ? result : pc_q + 16'd1;
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
      begin
         c_q <= 1'b0;
         z_q <= 1'b0;
      end
      else if (run && state_q == exec)
      begin
         c_q <= carry;
         z_q <= zero;
      end
   end

   // compares write to r0, which reads back as zero.
   always_ff @(posedge clk)
   begin
      if (run && state_q == exec)
         grf_q[ir_q[IRCMP] ? 4'h0 : ir_q[3:0]] <= result;
   end

   always_ff @(posedge clk)
   begin
      if (run && (state_q == fetch0 || state_q == exec))
         ir_q <= {(din[11:8] == OP_CMP) || (din[11:8] == OP_CMPC),
                  {2{din[11:8] == OP_PSR}} & {din[3:0] == 4'h0, din[7:4] == 4'h0},
                  din[11:8] == OP_STO,
                  din[11:8] == OP_LD,
                  din};
   end

endmodule

// File: hw/opc_local_mem.sv
`timescale 1ns/1ns

module opc_local_mem #(
   parameter int MEM_AW = 8
) (
   input  logic              clk,
   input  logic [MEM_AW-1:0] raddr,
   output opc_pkg::word_t    rdata,
   input  logic              we,
   input  logic [MEM_AW-1:0] waddr,
   input  opc_pkg::word_t    wdata
);
   import opc_pkg::*;

   word_t mem_q [2**MEM_AW];

   // read is combinational; the core samples din in the cycle it drives address.
   assign rdata = mem_q[raddr];

   always_ff @(posedge clk)
   begin
      if (we)
         mem_q[waddr] <= wdata;
   end

endmodule

// File: hw/opc_tile.sv
`timescale 1ns/1ns

module opc_tile #(
   parameter int MEM_AW = 8
) (
   input  logic              clk,
   input  logic              reset_b,
   input  logic              run,
   input  logic              load_we,
   input  logic [MEM_AW-1:0] load_addr,
   input  opc_pkg::word_t    load_data,
   output logic              io_stb,
   output opc_pkg::word_t    io_data
);
   import opc_pkg::*;

   word_t             cpu_din;
   word_t             cpu_dout;
   word_t             cpu_addr;
   logic              cpu_rnw;
   logic              out_wr;
   logic              core_mem_wr;
   logic              mem_we;
   logic [MEM_AW-1:0] mem_waddr;
   word_t             mem_wdata;

   opc_cpu u_opc_cpu (
      .clk     (clk),
      .reset_b (reset_b),
      .run     (run),
      .din     (cpu_din),
      .dout    (cpu_dout),
      .address (cpu_addr),
      .rnw     (cpu_rnw)
   );

   // --------------------
   // store decode
   assign out_wr      = !cpu_rnw && (cpu_addr == OUT_ADDR);
   assign core_mem_wr = !cpu_rnw && !out_wr;

   assign io_stb  = out_wr;
   assign io_data = cpu_dout;

   // loader only gets the port when the core leaves it free.
   assign mem_we    = core_mem_wr || load_we;
   assign mem_waddr = core_mem_wr ? cpu_addr[MEM_AW-1:0] : load_addr;
   assign mem_wdata = core_mem_wr ? cpu_dout : load_data;

   opc_local_mem #(
      .MEM_AW (MEM_AW)
   ) u_opc_local_mem (
      .clk   (clk),
      .raddr (cpu_addr[MEM_AW-1:0]),
      .rdata (cpu_din),
      .we    (mem_we),
      .waddr (mem_waddr),
      .wdata (mem_wdata)
   );

endmodule

// File: hw/opc_loader.sv
`timescale 1ns/1ns

module opc_loader #(
   parameter int NUM_CORES = 4,
   parameter int MEM_AW    = 8
) (
   input  logic                 clk,
   input  logic                 reset_b,
   input  logic                 load_we,
   input  opc_pkg::core_idx_t   load_core,
   input  logic [MEM_AW-1:0]    load_addr,
   input  opc_pkg::word_t       load_data,
   input  logic [NUM_CORES-1:0] run_set,
   input  logic [NUM_CORES-1:0] run_clr,
   output logic [NUM_CORES-1:0] tile_run,
   output logic [NUM_CORES-1:0] tile_we,
   output logic [MEM_AW-1:0]    tile_addr,
   output opc_pkg::word_t       tile_data
);
   import opc_pkg::*;

   logic [NUM_CORES-1:0] run_q;

   // clear beats set.
   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         run_q <= '0;
      else
         run_q <= (run_q | run_set) & ~run_clr;
   end

   assign tile_run = run_q;

   // --------------------
   // load routing
   always_comb
   begin
      for (int i = 0; i < NUM_CORES; i++)
         tile_we[i] = load_we && (load_core == core_idx_t'(i));
   end

   assign tile_addr = load_addr;
   assign tile_data = load_data;

endmodule

// File: hw/opc_collector.sv
`timescale 1ns/1ns

module opc_collector #(
   parameter int NUM_CORES = 4
) (
   input  logic                 clk,
   input  logic                 reset_b,
   input  logic [NUM_CORES-1:0] io_stb,
   input  opc_pkg::word_t       io_data [NUM_CORES],
   output logic                 out_valid,
   output opc_pkg::core_idx_t   out_core,
   output opc_pkg::word_t       out_data
);
   import opc_pkg::*;

   word_t                head [NUM_CORES];
   logic [NUM_CORES-1:0] pending;
   logic [NUM_CORES-1:0] pop;
   core_idx_t            ptr_q;
   core_idx_t            sel;
   logic                 sel_valid;

   // --------------------
   // per-core buffers
   for (genvar i = 0; i < NUM_CORES; i++)
   begin : g_buf
      word_t      entry_q [2];
      logic [1:0] cnt_q;
      logic       wr_slot;

      assign pending[i] = (cnt_q != 2'd0);
      assign pop[i]     = sel_valid && (sel == core_idx_t'(i));
      assign head[i]    = entry_q[0];

      // new word lands behind whatever survives the pop.
      assign wr_slot = (cnt_q == 2'd2) || (cnt_q == 2'd1 && !pop[i]);

      always_ff @(posedge clk or negedge reset_b)
      begin
         if (!reset_b)
            cnt_q <= 2'd0;
         else
            cnt_q <= cnt_q + {1'b0, io_stb[i]} - {1'b0, pop[i]};
      end

      always_ff @(posedge clk)
      begin
         if (pop[i])
            entry_q[0] <= entry_q[1];
         if (io_stb[i])
            entry_q[wr_slot] <= io_data[i];
      end
   end

   // --------------------
   // round robin
   // search starts at ptr_q; lowest offset wins.
   always_comb
   begin
      int idx;
      sel       = ptr_q;
      sel_valid = 1'b0;
      for (int k = NUM_CORES - 1; k >= 0; k--)
      begin
         idx = (int'(ptr_q) + k) % NUM_CORES;
         if (pending[idx])
         begin
            sel       = core_idx_t'(idx);
            sel_valid = 1'b1;
         end
      end
   end

   always_ff @(posedge clk or negedge reset_b)
   begin
      if (!reset_b)
         ptr_q <= '0;
      else if (sel_valid)
         ptr_q <= (int'(sel) == NUM_CORES - 1) ? core_idx_t'(0) : sel + core_idx_t'(1);
   end

   assign out_valid = sel_valid;
   assign out_core  = sel;
   assign out_data  = head[sel];

endmodule

// File: hw/opc_cluster.sv
`timescale 1ns/1ns

module opc_cluster #(
   parameter int NUM_CORES = 4,
   parameter int MEM_AW    = 8
) (
   input  logic                 clk,
   input  logic                 reset_b,
   input  logic                 load_we,
   input  opc_pkg::core_idx_t   load_core,
   input  logic [MEM_AW-1:0]    load_addr,
   input  opc_pkg::word_t       load_data,
   input  logic [NUM_CORES-1:0] run_set,
   input  logic [NUM_CORES-1:0] run_clr,
   output logic                 out_valid,
   output opc_pkg::core_idx_t   out_core,
   output opc_pkg::word_t       out_data
);
   import opc_pkg::*;

   logic [NUM_CORES-1:0] tile_run;
   logic [NUM_CORES-1:0] tile_we;
   logic [MEM_AW-1:0]    tile_addr;
   word_t                tile_data;
   logic [NUM_CORES-1:0] io_stb;
   word_t                io_data [NUM_CORES];

   opc_loader #(
      .NUM_CORES (NUM_CORES),
      .MEM_AW    (MEM_AW)
   ) u_opc_loader (
      .clk       (clk),
      .reset_b   (reset_b),
      .load_we   (load_we),
      .load_core (load_core),
      .load_addr (load_addr),
      .load_data (load_data),
      .run_set   (run_set),
      .run_clr   (run_clr),
      .tile_run  (tile_run),
      .tile_we   (tile_we),
      .tile_addr (tile_addr),
      .tile_data (tile_data)
   );

   // --------------------
   // core tiles
   for (genvar i = 0; i < NUM_CORES; i++)
   begin : g_tile
      opc_tile #(
         .MEM_AW (MEM_AW)
      ) u_opc_tile (
         .clk       (clk),
         .reset_b   (reset_b),
         .run       (tile_run[i]),
         .load_we   (tile_we[i]),
         .load_addr (tile_addr),
         .load_data (tile_data),
         .io_stb    (io_stb[i]),
         .io_data   (io_data[i])
      );
   end

   opc_collector #(
      .NUM_CORES (NUM_CORES)
   ) u_opc_collector (
      .clk       (clk),
      .reset_b   (reset_b),
      .io_stb    (io_stb),
      .io_data   (io_data),
      .out_valid (out_valid),
      .out_core  (out_core),
      .out_data  (out_data)
   );

endmodule

// File: tests/tb_opc_tests.svh
// instruction word is {pred[2:0], long, opcode, src, dst}.
localparam logic [2:0] P_ALW   = 3'b110;
localparam logic [2:0] P_NZ    = 3'b101;
localparam logic [3:0] OP_MOV  = 4'h0;
localparam logic [3:0] OP_AND  = 4'h1;
localparam logic [3:0] OP_OR   = 4'h2;
localparam logic [3:0] OP_XOR  = 4'h3;
localparam logic [3:0] OP_ADD  = 4'h4;
localparam logic [3:0] OP_ADC  = 4'h5;
localparam logic [3:0] OP_STO  = 4'h6;
localparam logic [3:0] OP_LD   = 4'h7;
localparam logic [3:0] OP_ROR  = 4'h8;
localparam logic [3:0] OP_NOT  = 4'h9;
localparam logic [3:0] OP_SUB  = 4'hA;
localparam logic [3:0] OP_BSWP = 4'hE;

// --------------------
// program assembly
task automatic short_op(input logic [2:0] pred, input logic [3:0] op,
                        input logic [3:0] src, input logic [3:0] dst);
   prog.push_back({pred, 1'b0, op, src, dst});
endtask

task automatic long_op(input logic [2:0] pred, input logic [3:0] op,
                       input logic [3:0] src, input logic [3:0] dst, input word_t imm);
   prog.push_back({pred, 1'b1, op, src, dst});
   prog.push_back(imm);
endtask

// r15 is the pc.
task automatic jump(input logic [2:0] pred, input int target);
   long_op(pred, OP_MOV, 4'h0, 4'hF, word_t'(target));
endtask

task automatic halt_here();
   jump(P_ALW, prog.size());
endtask

// r14 holds the output address in every program.
task automatic start_program();
   prog.delete();
   long_op(P_ALW, OP_MOV, 4'h0, 4'hE, OUT_ADDR);
endtask

task automatic out_store(input logic [3:0] rs);
   short_op(P_ALW, OP_STO, 4'hE, rs);
endtask

// --------------------
// load side and output capture
task automatic poke(input core_idx_t core, input int addr, input word_t data);
   @(posedge clk);
   load_we   <= 1'b1;
   load_core <= core;
   load_addr <= MEM_AW'(addr);
   load_data <= data;
   @(posedge clk);
   load_we   <= 1'b0;
endtask

task automatic load_program(input core_idx_t core);
   foreach (prog[i])
      poke(core, i, prog[i]);
endtask

task automatic pulse_run(input logic [3:0] set_mask, input logic [3:0] clr_mask);
   @(posedge clk);
   run_set <= set_mask;
   run_clr <= clr_mask;
   @(posedge clk);
   run_set <= '0;
   run_clr <= '0;
endtask

task automatic clear_log();
   out_log.delete();
   foreach (out_cnt[i])
      out_cnt[i] = 0;
endtask

// compares one core's words, in order, against exp_q.
task automatic expect_stream(input core_idx_t core, input string name);
   int n;
   n = 0;
   while (out_cnt[core] < exp_q.size())
      @(posedge clk);
   foreach (out_log[i])
   begin
      if (out_log[i][17:16] == core && n < exp_q.size())
      begin
         check(out_log[i][15:0], exp_q[n], $sformatf("%s word %0d", name, n));
         n++;
      end
   end
endtask

task automatic expect_no_more(input core_idx_t core, input string name);
   repeat (100) @(posedge clk);
   check(out_cnt[core], exp_q.size(), $sformatf("%s word count", name));
endtask

// --------------------
// directed tests
task automatic alu_results();
   word_t       a;
   word_t       b;
   logic [16:0] sum;
   logic        c;
   // both top bits set so the add carries into adc.
   a = word_t'($random(seed)) | 16'h8001;
   b = word_t'($random(seed)) | 16'h8000;
   exp_q.delete();
   start_program();
   long_op(P_ALW, OP_MOV, 4'h0, 4'h1, a);
   long_op(P_ALW, OP_MOV, 4'h0, 4'h2, b);
   // each binary op starts from a fresh copy of r1 in r3.
   for (int i = 0; i < 6; i++)
   begin
      short_op(P_ALW, OP_MOV, 4'h1, 4'h3);
      short_op(P_ALW, i == 0 ? OP_ADD : i == 1 ? OP_ADC : i == 2 ? OP_SUB :
                      i == 3 ? OP_AND : i == 4 ? OP_OR : OP_XOR, 4'h2, 4'h3);
      out_store(4'h3);
   end
   sum = {1'b0, a} + {1'b0, b};
   exp_q.push_back(sum[15:0]);
   c = sum[16];
   sum = {1'b0, a} + {1'b0, b} + {16'b0, c};
   exp_q.push_back(sum[15:0]);
   c = sum[16];
   // carry means no borrow.
   exp_q.push_back(a - b);
   c = (a >= b);
   exp_q.push_back(a & b);
   exp_q.push_back(a | b);
   exp_q.push_back(a ^ b);
   // unary ops work on r1 directly.
   short_op(P_ALW, OP_NOT, 4'h1, 4'h3);
   out_store(4'h3);
   exp_q.push_back(~a);
   for (int i = 0; i < 2; i++)
   begin
      short_op(P_ALW, OP_ROR, 4'h1, 4'h3);
      out_store(4'h3);
      exp_q.push_back({c, a[15:1]});
      c = a[0];
   end
   short_op(P_ALW, OP_BSWP, 4'h1, 4'h3);
   out_store(4'h3);
   exp_q.push_back({a[7:0], a[15:8]});
   halt_here();
   load_program(2'd0);
   clear_log();
   pulse_run(4'b0001, 4'b0000);
   expect_stream(2'd0, "alu");
   expect_no_more(2'd0, "alu");
endtask

task automatic predicated_loop();
   int loop;
   int count;
   count = 6;
   exp_q.delete();
   start_program();
   long_op(P_ALW, OP_LD, 4'h0, 4'h1, 16'h0040);
   loop = prog.size();
   out_store(4'h1);
   long_op(P_ALW, OP_SUB, 4'h0, 4'h1, 16'd1);
   jump(P_NZ, loop);
   out_store(4'h1);
   halt_here();
   load_program(2'd1);
   poke(2'd1, 'h40, word_t'(count));
   for (int i = count; i >= 0; i--)
      exp_q.push_back(word_t'(i));
   clear_log();
   pulse_run(4'b0010, 4'b0000);
   expect_stream(2'd1, "countdown");
   expect_no_more(2'd1, "countdown");
endtask

task automatic memory_roundtrip();
   word_t tbl [4];
   word_t data;
   exp_q.delete();
   data = word_t'($random(seed));
   start_program();
   long_op(P_ALW, OP_MOV, 4'h0, 4'h2, 16'h0060);
   for (int k = 0; k < 4; k++)
   begin
      tbl[k] = word_t'($random(seed));
      long_op(P_ALW, OP_MOV, 4'h0, 4'h1, tbl[k]);
      long_op(P_ALW, OP_STO, 4'h2, 4'h1, word_t'(k));
   end
   for (int k = 0; k < 4; k++)
   begin
      long_op(P_ALW, OP_LD, 4'h2, 4'h3, word_t'(k));
      out_store(4'h3);
      exp_q.push_back(tbl[k]);
   end
   // preloaded word passes through untouched.
   long_op(P_ALW, OP_LD, 4'h0, 4'h4, 16'h0080);
   out_store(4'h4);
   exp_q.push_back(data);
   halt_here();
   load_program(2'd2);
   poke(2'd2, 'h80, data);
   clear_log();
   pulse_run(4'b0100, 4'b0000);
   expect_stream(2'd2, "memory");
   expect_no_more(2'd2, "memory");
endtask

task automatic concurrent_cores();
   int loop;
   pulse_run(4'b0000, 4'b1111);
   for (int c = 0; c < 4; c++)
   begin
      start_program();
      long_op(P_ALW, OP_MOV, 4'h0, 4'h1, word_t'((c + 1) << 12));
      long_op(P_ALW, OP_MOV, 4'h0, 4'h2, word_t'(3 + c));
      loop = prog.size();
      // same address in every tile; each must read back its own value.
      long_op(P_ALW, OP_STO, 4'h0, 4'h1, 16'h0070);
      long_op(P_ALW, OP_LD, 4'h0, 4'h3, 16'h0070);
      out_store(4'h3);
      long_op(P_ALW, OP_ADD, 4'h0, 4'h1, 16'd1);
      long_op(P_ALW, OP_SUB, 4'h0, 4'h2, 16'd1);
      jump(P_NZ, loop);
      halt_here();
      load_program(core_idx_t'(c));
   end
   clear_log();
   pulse_run(4'b1111, 4'b0000);
   for (int c = 0; c < 4; c++)
   begin
      exp_q.delete();
      for (int i = 0; i < 3 + c; i++)
         exp_q.push_back(word_t'(((c + 1) << 12) + i));
      expect_stream(core_idx_t'(c), $sformatf("core %0d concurrent", c));
      expect_no_more(core_idx_t'(c), $sformatf("core %0d concurrent", c));
   end
endtask

task automatic run_control();
   int loop;
   int n;
   pulse_run(4'b0000, 4'b1000);
   start_program();
   long_op(P_ALW, OP_MOV, 4'h0, 4'h1, 16'd0);
   loop = prog.size();
   long_op(P_ALW, OP_ADD, 4'h0, 4'h1, 16'd1);
   out_store(4'h1);
   jump(P_ALW, loop);
   load_program(2'd3);
   exp_q.delete();
   for (int i = 1; i <= 4; i++)
      exp_q.push_back(word_t'(i));
   clear_log();
   pulse_run(4'b1000, 4'b0000);
   expect_stream(2'd3, "first run");
   pulse_run(4'b0000, 4'b1000);
   // let the collector drain.
   repeat (10) @(posedge clk);
   n = out_cnt[3];
   repeat (200) @(posedge clk);
   check(out_cnt[3], n, "words from a stopped core");
   clear_log();
   pulse_run(4'b1000, 4'b0000);
   expect_stream(2'd3, "after restart");
   pulse_run(4'b0000, 4'b1000);
endtask

// File: tests/tb_opc_cluster.sv
`timescale 1ns/1ns

module tb_opc_cluster;
   import opc_pkg::*;

   localparam int NUM_CORES  = 4;
   localparam int MEM_AW     = 8;
   // about 4000 cycles of programs, five times over.
   localparam int MAX_CYCLES = 20000;

   logic                 clk;
   logic                 reset_b;
   logic                 load_we;
   core_idx_t            load_core;
   logic [MEM_AW-1:0]    load_addr;
   word_t                load_data;
   logic [NUM_CORES-1:0] run_set;
   logic [NUM_CORES-1:0] run_clr;
   logic                 out_valid;
   core_idx_t            out_core;
   word_t                out_data;

   int unsigned          cycles = 0;
   int                   err_cnt;
   int                   seed;
   // each entry is {core, word}, in arrival order.
   logic [17:0]          out_log [$];
   int                   out_cnt [NUM_CORES];
   word_t                prog [$];
   word_t                exp_q [$];

   opc_cluster #(
      .NUM_CORES (NUM_CORES),
      .MEM_AW    (MEM_AW)
   ) u_opc_cluster (
      .clk       (clk),
      .reset_b   (reset_b),
      .load_we   (load_we),
      .load_core (load_core),
      .load_addr (load_addr),
      .load_data (load_data),
      .run_set   (run_set),
      .run_clr   (run_clr),
      .out_valid (out_valid),
      .out_core  (out_core),
      .out_data  (out_data)
   );

   always #5 clk = ~clk;

   // --------------------
   // output monitor
   always @(negedge clk)
   begin
      if (reset_b && out_valid)
      begin
         out_log.push_back({out_core, out_data});
         out_cnt[out_core] = out_cnt[out_core] + 1;
      end
   end

   always @(posedge clk)
   begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("tests failed");
         $fatal(1, "simulation aborted");
      end
   end

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
      if (got !== exp)
      begin
         err_cnt++;
         $display("FAIL at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
         $display("tests failed");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   `include "tb_opc_tests.svh"

   // --------------------
   // test sequence
   initial
   begin
      clk       = 1'b0;
      reset_b   = 1'b0;
      load_we   = 1'b0;
      load_core = '0;
      load_addr = '0;
      load_data = '0;
      run_set   = '0;
      run_clr   = '0;
      err_cnt   = 0;
      seed      = 32'h5c1d_d25e;
      clear_log();
      repeat (2) @(posedge clk);
      reset_b <= 1'b1;

      alu_results();
      predicated_loop();
      memory_roundtrip();
      concurrent_cores();
      run_control();

      if (err_cnt == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

// File: sources.f
+incdir+tests
hw/opc_pkg.sv
hw/opc_cpu.sv
hw/opc_local_mem.sv
hw/opc_tile.sv
hw/opc_loader.sv
hw/opc_collector.sv
hw/opc_cluster.sv
tests/tb_opc_cluster.sv

// File: Bender.yml
package:
  name: opc_cluster

sources:
  - hw/opc_pkg.sv
  - hw/opc_cpu.sv
  - hw/opc_local_mem.sv
  - hw/opc_tile.sv
  - hw/opc_loader.sv
  - hw/opc_collector.sv
  - hw/opc_cluster.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_opc_cluster.sv
